// ==== pool_macros.svh ====
`ifndef POOL_MACROS_SVH
`define POOL_MACROS_SVH

// feature value and descriptor word widths
`define POOL_DATA_W 8
`define POOL_WORD_W 32

// width of a row, channel or kernel count
`define POOL_DIM_W 8

// input feature ram
`define POOL_IN_DEPTH 1024
`define POOL_IN_AW 10

// descriptor ram, three words used
`define POOL_PARAM_DEPTH 8
`define POOL_PARAM_AW 3

// result fifo entries, also the number of windows in flight
`define POOL_FIFO_DEPTH 4

// consumer buffer size after reset
`define POOL_OUT_CREDITS 2

`endif

// ==== pool_cfg_pkg.sv ====
`default_nettype none

`include "pool_macros.svh"

package pool_cfg_pkg;

	// row, channel or kernel count
	typedef logic [`POOL_DIM_W-1:0] dim_t;

	// where each field sits in the descriptor ram
	typedef enum logic [`POOL_PARAM_AW-1:0] {
		CFG_WORD_ROW     = 0,
		CFG_WORD_CHANNEL = 1,
		CFG_WORD_KERNEL  = 2
	} cfg_word_e;

	// layer descriptor as captured by the loader
	typedef struct packed {
		dim_t num_row;
		dim_t num_channel;
		dim_t kernel;
	} layer_cfg_t;

endpackage

`default_nettype wire

// ==== pool_data_pkg.sv ====
`default_nettype none

`include "pool_macros.svh"

package pool_data_pkg;

	// one signed feature value
	typedef logic signed [`POOL_DATA_W-1:0] pix_t;

	// input ram word address
	typedef logic [`POOL_IN_AW-1:0] in_addr_t;

	// position of a beat inside its window
	typedef struct packed {
		logic first;
		logic last;
	} fetch_tag_t;

	// one closed window
	typedef struct packed {
		pix_t value;
		logic last_of_layer;
	} result_t;

endpackage

`default_nettype wire

// ==== feature_ram.sv ====
`default_nettype none

module feature_ram #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 1024
) (
	input  wire                     clk,
	input  wire                     we,
	input  wire [$clog2(DEPTH)-1:0] waddr,
	input  wire [WIDTH-1:0]         wdata,
	input  wire [$clog2(DEPTH)-1:0] raddr,
	output logic [WIDTH-1:0]        rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// host side write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// engine side read, data one cycle after the address
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== pool_param_loader.sv ====
`default_nettype none

`include "pool_macros.svh"

module pool_param_loader (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          start,
	output logic [`POOL_PARAM_AW-1:0]    param_raddr,
	input  wire [`POOL_WORD_W-1:0]       param_rdata,
	output pool_cfg_pkg::layer_cfg_t     cfg,
	output logic                         cfg_valid
);

	import pool_cfg_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		PUBLISH
	} state_e;

	state_e                    state;
	logic [`POOL_PARAM_AW-1:0] word_cnt;
	dim_t                      word_val;

	// counts live in the low byte of each word
	assign word_val = dim_t'(param_rdata);

	// idle keeps word 0 on the bus so it is ready the cycle after start
	always_comb begin
		if (state == READ) begin
			param_raddr = word_cnt + 1'b1;
		end else begin
			param_raddr = CFG_WORD_ROW;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state    <= IDLE;
			word_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					word_cnt <= '0;
					if (start) begin
						state <= READ;
					end
				end
				READ: begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == CFG_WORD_KERNEL) begin
						state <= PUBLISH;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// word_cnt names the word now on param_rdata
	always_ff @(posedge clk) begin
		if (state == READ) begin
			case (word_cnt)
				CFG_WORD_ROW:     cfg.num_row <= word_val;
				CFG_WORD_CHANNEL: cfg.num_channel <= word_val;
				default:          cfg.kernel <= word_val;
			endcase
		end
	end

	assign cfg_valid = (state == PUBLISH);

	kernel_legal: assert property (@(posedge clk) disable iff (!rst)
		cfg_valid |-> (cfg.kernel == 8'd2 || cfg.kernel == 8'd8));

endmodule

`default_nettype wire

// ==== pool_window_fetch.sv ====
`default_nettype none

`include "pool_macros.svh"

module pool_window_fetch (
	input  wire                          clk,
	input  wire                          rst,
	input  wire pool_cfg_pkg::layer_cfg_t cfg,
	input  wire                          cfg_valid,
	input  wire                          win_credit,
	output pool_data_pkg::in_addr_t      rd_addr,
	output logic                         beat_valid,
	output pool_data_pkg::fetch_tag_t    beat_tag,
	output logic                         last_window
);

	import pool_cfg_pkg::*;
	import pool_data_pkg::*;

	localparam int CRED_W = $clog2(`POOL_FIFO_DEPTH + 1);

	typedef enum logic {
		IDLE,
		SCAN
	} state_e;

	state_e            state;
	dim_t              ch;
	dim_t              win_row;
	dim_t              win_col;
	dim_t              el_row;
	dim_t              el_col;
	dim_t              k_last;
	dim_t              win_last;
	logic [CRED_W-1:0] credit;
	logic              rd_valid;
	logic              take;
	logic              first_el;
	logic              last_el;
	logic              last_win_now;
	fetch_tag_t        tag_now;
	in_addr_t          ch_base;
	in_addr_t          row_idx;
	in_addr_t          col_idx;

	assign k_last = cfg.kernel - 1'b1;

	// windows per row and column, minus one
	assign win_last = ((cfg.kernel == 8'd2) ? (cfg.num_row >> 1) : (cfg.num_row >> 3)) - 1'b1;

	assign first_el     = (el_row == '0) && (el_col == '0);
	assign last_el      = (el_row == k_last) && (el_col == k_last);
	assign last_win_now = (ch == cfg.num_channel - 1'b1) && (win_row == win_last) &&
		(win_col == win_last);

	// a new window needs a free fifo slot, the rest of a window does not
	assign rd_valid = (state == SCAN) && (!first_el || credit != '0);
	assign take     = rd_valid && first_el;

	assign tag_now.first = first_el;
	assign tag_now.last  = last_el;

	// channel base plus row and column inside the channel plane
	assign ch_base = ch * cfg.num_row * cfg.num_row;
	assign row_idx = win_row * cfg.kernel + el_row;
	assign col_idx = win_col * cfg.kernel + el_col;
	assign rd_addr = ch_base + row_idx * cfg.num_row + col_idx;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state   <= IDLE;
			ch      <= '0;
			win_row <= '0;
			win_col <= '0;
			el_row  <= '0;
			el_col  <= '0;
		end else if (state == IDLE) begin
			ch      <= '0;
			win_row <= '0;
			win_col <= '0;
			el_row  <= '0;
			el_col  <= '0;
			if (cfg_valid) begin
				state <= SCAN;
			end
		end else if (rd_valid) begin
			if (el_col != k_last) begin
				el_col <= el_col + 1'b1;
			end else begin
				el_col <= '0;
				if (el_row != k_last) begin
					el_row <= el_row + 1'b1;
				end else begin
					el_row <= '0;
					if (last_win_now) begin
						state <= IDLE;
					end else if (win_col != win_last) begin
						win_col <= win_col + 1'b1;
					end else begin
						win_col <= '0;
						if (win_row != win_last) begin
							win_row <= win_row + 1'b1;
						end else begin
							win_row <= '0;
							ch      <= ch + 1'b1;
						end
					end
				end
			end
		end
	end

	// one slot per window, given back when the fifo pops
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			credit <= CRED_W'(`POOL_FIFO_DEPTH);
		end else begin
			credit <= credit - CRED_W'(take) + CRED_W'(win_credit);
		end
	end

	// line the tag up with ram read data
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			beat_valid <= 1'b0;
		end else begin
			beat_valid <= rd_valid;
		end
	end

	always_ff @(posedge clk) begin
		beat_tag    <= tag_now;
		last_window <= last_win_now;
	end

	credit_bound: assert property (@(posedge clk) disable iff (!rst)
		credit <= CRED_W'(`POOL_FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== pool_max_reduce.sv ====
`default_nettype none

module pool_max_reduce (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       beat_valid,
	input  wire pool_data_pkg::fetch_tag_t beat_tag,
	input  wire                       last_window,
	input  wire pool_data_pkg::pix_t  rdata,
	output logic                      res_valid,
	output pool_data_pkg::result_t    res
);

	import pool_data_pkg::*;

	pix_t acc;
	pix_t win_max;
	logic win_open;

	// first beat restarts the window, signed compare otherwise
	assign win_max = (beat_tag.first || rdata > acc) ? rdata : acc;

	always_ff @(posedge clk) begin
		if (beat_valid) begin
			acc <= win_max;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			win_open <= 1'b0;
		end else if (beat_valid) begin
			if (beat_tag.last) begin
				win_open <= 1'b0;
			end else if (beat_tag.first) begin
				win_open <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			res_valid <= 1'b0;
		end else begin
			res_valid <= beat_valid && beat_tag.last;
		end
	end

	// close the window
	always_ff @(posedge clk) begin
		if (beat_valid && beat_tag.last) begin
			res.value         <= win_max;
			res.last_of_layer <= last_window;
		end
	end

	last_needs_open: assert property (@(posedge clk) disable iff (!rst)
		(beat_valid && beat_tag.last) |-> (win_open || beat_tag.first));

endmodule

`default_nettype wire

// ==== pool_result_port.sv ====
`default_nettype none

`include "pool_macros.svh"

module pool_result_port (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          start,
	input  wire                          res_valid,
	input  wire pool_data_pkg::result_t  res,
	input  wire                          out_credit,
	output logic                         out_valid,
	output pool_data_pkg::pix_t          out_data,
	output logic                         win_credit,
	output logic                         done
);

	import pool_data_pkg::*;

	// pointers wrap on their own since depth is a power of two
	localparam int PTR_W  = $clog2(`POOL_FIFO_DEPTH);
	localparam int CNT_W  = $clog2(`POOL_FIFO_DEPTH + 1);
	localparam int CRED_W = $clog2(`POOL_OUT_CREDITS + 1);

	result_t           fifo_mem [`POOL_FIFO_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic [CRED_W-1:0] credit;
	logic              pop;
	logic              out_last;
	result_t           head;

	assign head = fifo_mem[rd_ptr];

	// send only into free consumer buffer space
	assign pop = (count != '0) && (credit != '0);

	always_ff @(posedge clk) begin
		if (res_valid) begin
			fifo_mem[wr_ptr] <= res;
		end
	end

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credit     <= CRED_W'(`POOL_OUT_CREDITS);
			out_valid  <= 1'b0;
			win_credit <= 1'b0;
		end else begin
			if (res_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count      <= count + CNT_W'(res_valid) - CNT_W'(pop);
			credit     <= credit - CRED_W'(pop) + CRED_W'(out_credit);
			out_valid  <= pop;
			win_credit <= pop;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			out_data <= head.value;
			out_last <= head.last_of_layer;
		end
	end

	// held until the next layer starts
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			done <= 1'b0;
		end else if (start) begin
			done <= 1'b0;
		end else if (out_valid && out_last) begin
			done <= 1'b1;
		end
	end

	no_push_full: assert property (@(posedge clk) disable iff (!rst)
		res_valid |-> (count != CNT_W'(`POOL_FIFO_DEPTH)));

	// the consumer never returns more credits than it was given
	credit_in_range: assert property (@(posedge clk) disable iff (!rst)
		credit <= CRED_W'(`POOL_OUT_CREDITS));

endmodule

`default_nettype wire

// ==== pool_accel_top.sv ====
`default_nettype none

`include "pool_macros.svh"

module pool_accel_top (
	input  wire                          clk,
	input  wire                          rst,
	input  wire                          param_we,
	input  wire [`POOL_PARAM_AW-1:0]     param_waddr,
	input  wire [`POOL_WORD_W-1:0]       param_wdata,
	input  wire                          in_we,
	input  wire pool_data_pkg::in_addr_t in_waddr,
	input  wire pool_data_pkg::pix_t     in_wdata,
	input  wire                          start,
	output logic                         done,
	output logic                         out_valid,
	output pool_data_pkg::pix_t          out_data,
	input  wire                          out_credit
);

	import pool_cfg_pkg::*;
	import pool_data_pkg::*;

	logic [`POOL_PARAM_AW-1:0] param_raddr;
	logic [`POOL_WORD_W-1:0]   param_rdata;
	layer_cfg_t                cfg;
	logic                      cfg_valid;
	in_addr_t                  rd_addr;
	pix_t                      in_rdata;
	logic                      beat_valid;
	fetch_tag_t                beat_tag;
	logic                      last_window;
	logic                      res_valid;
	result_t                   res;
	logic                      win_credit;

	feature_ram #(
		.WIDTH(`POOL_WORD_W),
		.DEPTH(`POOL_PARAM_DEPTH)
	) param_ram (
		.clk  (clk),
		.we   (param_we),
		.waddr(param_waddr),
		.wdata(param_wdata),
		.raddr(param_raddr),
		.rdata(param_rdata)
	);

	feature_ram #(
		.WIDTH(`POOL_DATA_W),
		.DEPTH(`POOL_IN_DEPTH)
	) in_ram (
		.clk  (clk),
		.we   (in_we),
		.waddr(in_waddr),
		.wdata(in_wdata),
		.raddr(rd_addr),
		.rdata(in_rdata)
	);

	pool_param_loader u_loader (
		.clk        (clk),
		.rst        (rst),
		.start      (start),
		.param_raddr(param_raddr),
		.param_rdata(param_rdata),
		.cfg        (cfg),
		.cfg_valid  (cfg_valid)
	);

	pool_window_fetch u_fetch (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg),
		.cfg_valid  (cfg_valid),
		.win_credit (win_credit),
		.rd_addr    (rd_addr),
		.beat_valid (beat_valid),
		.beat_tag   (beat_tag),
		.last_window(last_window)
	);

	pool_max_reduce u_reduce (
		.clk        (clk),
		.rst        (rst),
		.beat_valid (beat_valid),
		.beat_tag   (beat_tag),
		.last_window(last_window),
		.rdata      (in_rdata),
		.res_valid  (res_valid),
		.res        (res)
	);

	pool_result_port u_result (
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.res_valid (res_valid),
		.res       (res),
		.out_credit(out_credit),
		.out_valid (out_valid),
		.out_data  (out_data),
		.win_credit(win_credit),
		.done      (done)
	);

endmodule

`default_nettype wire

// ==== tb_pool_accel.sv ====
`default_nettype none

`include "pool_macros.svh"

module tb_pool_accel;

	timeunit 1ns;
	timeprecision 100ps;

	import pool_data_pkg::*;

	// pixels loaded over all tests
	localparam int TOTAL_PIX  = 16 + 192 + 512 + 128 + 160;
	localparam int MAX_CYCLES = TOTAL_PIX * 4 + 2000;

	logic                      clk;
	logic                      rst;
	logic                      param_we;
	logic [`POOL_PARAM_AW-1:0] param_waddr;
	logic [`POOL_WORD_W-1:0]   param_wdata;
	logic                      in_we;
	in_addr_t                  in_waddr;
	pix_t                      in_wdata;
	logic                      start;
	logic                      done;
	logic                      out_valid;
	pix_t                      out_data;
	logic                      out_credit = 1'b0;

	pix_t        feat [`POOL_IN_DEPTH];
	pix_t        exp_q [$];
	pix_t        rx_q [$];
	int unsigned fill_state = 2;
	int unsigned credit_state = 2;
	int          credit_policy = 0;
	int          pending = 0;
	int          sent = 0;
	int          returned = 0;
	int          cycles = 0;

	pool_accel_top DUT (
		.clk        (clk),
		.rst        (rst),
		.param_we   (param_we),
		.param_waddr(param_waddr),
		.param_wdata(param_wdata),
		.in_we      (in_we),
		.in_waddr   (in_waddr),
		.in_wdata   (in_wdata),
		.start      (start),
		.done       (done),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_credit (out_credit)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// row-major planes stored one channel after the other
	function automatic int pix_index(input int rows, input int k, input int c, input int wr,
		input int wc, input int er, input int ec);
		return c * rows * rows + (wr * k + er) * rows + wc * k + ec;
	endfunction

	// expected maxima in channel, window row, window column order
	function automatic void ref_maxima(input int rows, input int chans, input int k);
		pix_t m;
		pix_t v;
		exp_q.delete();
		for (int c = 0; c < chans; c++) begin
			for (int wr = 0; wr < rows / k; wr++) begin
				for (int wc = 0; wc < rows / k; wc++) begin
					m = feat[pix_index(rows, k, c, wr, wc, 0, 0)];
					for (int er = 0; er < k; er++) begin
						for (int ec = 0; ec < k; ec++) begin
							v = feat[pix_index(rows, k, c, wr, wc, er, ec)];
							if (v > m) begin
								m = v;
							end
						end
					end
					exp_q.push_back(m);
				end
			end
		end
	endfunction

	task automatic check_eq(input integer actual, input integer expected, input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1, "stopped at first error");
		end
	endtask

	task automatic load_cfg(input int rows, input int chans, input int k);
		int words [3];
		words = '{rows, chans, k};
		for (int w = 0; w < 3; w++) begin
			@(negedge clk);
			param_we    = 1'b1;
			param_waddr = w[`POOL_PARAM_AW-1:0];
			param_wdata = words[w];
		end
		@(negedge clk);
		param_we = 1'b0;
	endtask

	// random map with planted negative and -128 windows in corner mode (kernel 2 only)
	task automatic fill_map(input int rows, input int chans, input int corners);
		int n;
		n = rows * rows * chans;
		for (int i = 0; i < n; i++) begin
			fill_state = lcg_next(fill_state);
			feat[i] = pix_t'(fill_state[23:16]);
		end
		if (corners != 0) begin
			for (int er = 0; er < 2; er++) begin
				for (int ec = 0; ec < 2; ec++) begin
					fill_state = lcg_next(fill_state);
					feat[pix_index(rows, 2, 0, 0, 0, er, ec)] = pix_t'(fill_state[23:16] | 8'h80);
					feat[pix_index(rows, 2, 0, 0, 1, er, ec)] = pix_t'(8'h80);
					feat[pix_index(rows, 2, 1, 1, 1, er, ec)] = pix_t'(fill_state[19:16]);
				end
			end
			// floor next to small positives
			feat[pix_index(rows, 2, 1, 1, 1, 0, 0)] = pix_t'(8'h80);
		end
		for (int i = 0; i < n; i++) begin
			@(negedge clk);
			in_we    = 1'b1;
			in_waddr = in_addr_t'(i);
			in_wdata = feat[i];
		end
		@(negedge clk);
		in_we = 1'b0;
	endtask

	// load, start, wait for done, drain credits, compare in order
	task automatic run_layer(input int rows, input int chans, input int k, input int corners,
		input int policy, input string name);
		load_cfg(rows, chans, k);
		fill_map(rows, chans, corners);
		ref_maxima(rows, chans, k);
		@(posedge clk);
		rx_q.delete();
		sent          = 0;
		returned      = 0;
		credit_policy = policy;
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		check_eq(done, 0, {name, ": done cleared by start"});
		while (!done) begin
			@(negedge clk);
		end
		@(posedge clk);
		credit_policy = 0;
		while (pending != 0) begin
			@(posedge clk);
		end
		// a stray result would land here
		repeat (8) @(posedge clk);
		check_eq(rx_q.size(), exp_q.size(), {name, ": result count"});
		for (int i = 0; i < exp_q.size(); i++) begin
			check_eq(rx_q[i], exp_q[i], $sformatf("%s: window %0d", name, i));
		end
	endtask

	// consumer with a buffer of POOL_OUT_CREDITS results
	always @(negedge clk) begin
		if (out_valid) begin
			sent++;
			pending++;
			rx_q.push_back(out_data);
			check_eq(int'(sent <= `POOL_OUT_CREDITS + returned), 1,
				"send without a free credit");
		end
		credit_state = lcg_next(credit_state);
		if (pending > 0 && (credit_policy == 0 || credit_state[26:24] == 3'd0)) begin
			out_credit = 1'b1;
			pending--;
			returned++;
		end else begin
			out_credit = 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > MAX_CYCLES) begin
			$display("timeout: the DUT did not finish within %0d cycles", MAX_CYCLES);
			$display("Test failed");
			$fatal(1, "run stopped by cycle limit");
		end
	end

	initial begin
		rst         = 1'b0;
		param_we    = 1'b0;
		param_waddr = '0;
		param_wdata = '0;
		in_we       = 1'b0;
		in_waddr    = '0;
		in_wdata    = '0;
		start       = 1'b0;
		repeat (5) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_eq(done, 0, "done after reset");
		check_eq(out_valid, 0, "out_valid after reset");

		run_layer(4, 1, 2, 0, 0, "4x4 k2");
		run_layer(8, 3, 2, 1, 0, "8x8x3 k2");
		run_layer(16, 2, 8, 0, 0, "16x16x2 k8");
		// credits come back rarely
		run_layer(8, 2, 2, 0, 1, "back-pressure");
		// new descriptor right after done
		run_layer(8, 2, 8, 0, 1, "first layer");
		run_layer(4, 2, 2, 0, 0, "second layer");

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pool_accel_top.f ====
+incdir+.
pool_cfg_pkg.sv
pool_data_pkg.sv
feature_ram.sv
pool_param_loader.sv
pool_window_fetch.sv
pool_max_reduce.sv
pool_result_port.sv
pool_accel_top.sv
tb_pool_accel.sv
